//--- Bender.yml
package:
  name: sprite_engine

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/sprite_pkg.sv
      - common/wb_pkg.sv
      - hw/draw_sprite/sprite_addr.sv
      - hw/draw_sprite/draw_sprite.sv
      - hw/sprite_store.sv
      - hw/frame_buffer.sv
      - hw/sprite_engine.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/sprite_engine_asserts.sv
      - verification/tb_sprite_engine.sv

//--- common/sprite_cfg.svh
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

// Visible screen in pixels.
`define SCREEN_W 640
`define SCREEN_H 480

// Sprites are square and stored in row order.
`define SPRITE_DIM 8
`define SPRITE_PIX 64

// Number of bits that select one of the stored images.
`define IMG_BITS 8

// Linear frame address, y * SCREEN_W + x.
`define FB_ADDR_BITS 19

// Sprite store address is {image, pixel index}.
`define ROM_ADDR_BITS 14

// 8 bits per channel.
`define COLOR_BITS 24

`endif

//--- common/sprite_pkg.sv
`include "sprite_cfg.svh"

package sprite_pkg;

	typedef logic [`COLOR_BITS-1:0] color_t;

	// Position of the top left sprite pixel and the image to draw.
	typedef struct packed {
		logic [9:0]           x;
		logic [8:0]           y;
		logic [`IMG_BITS-1:0] img;
	} sprite_cmd_t;

	// One word of the sprite store.
	typedef struct packed {
		logic [6:0] rsvd;
		logic       opaque; // Clear means the pixel is skipped.
		color_t     color;
	} sprite_word_t;

	typedef enum logic [1:0] {
		IDLE,
		READ,
		WRITE,
		ADVANCE
	} draw_state_e;

endpackage

//--- common/wb_pkg.sv
`include "sprite_cfg.svh"

package wb_pkg;

	// Read master request towards the sprite store.
	typedef struct packed {
		logic                      cyc;
		logic                      stb;
		logic [`ROM_ADDR_BITS-1:0] adr;
	} wb_rd_req_t;

	// Read slave response, dat holds a sprite word.
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rd_rsp_t;

	// Write master request towards the frame buffer.
	typedef struct packed {
		logic                     cyc;
		logic                     stb;
		logic                     we;
		logic [`FB_ADDR_BITS-1:0] adr;
		logic [`COLOR_BITS-1:0]   dat;
	} wb_wr_req_t;

	typedef struct packed {
		logic ack;
	} wb_wr_rsp_t;

endpackage

//--- hw/draw_sprite/draw_sprite.sv
`include "sprite_cfg.svh"

module draw_sprite (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  sprite_pkg::sprite_cmd_t cmd,
	output logic                    done,
	output logic                    busy,
	output wb_pkg::wb_rd_req_t      rom_req,
	input  wb_pkg::wb_rd_rsp_t      rom_rsp,
	output wb_pkg::wb_wr_req_t      fb_req,
	input  wb_pkg::wb_wr_rsp_t      fb_rsp
);

	localparam int PIX_BITS = $clog2(`SPRITE_PIX);

	sprite_pkg::draw_state_e  state;
	sprite_pkg::draw_state_e  next_state;
	sprite_pkg::sprite_cmd_t  cmd_q;
	sprite_pkg::sprite_word_t word_q;
	sprite_pkg::sprite_word_t rom_word;
	logic [PIX_BITS-1:0]      pix_cnt;
	logic [`FB_ADDR_BITS-1:0] fb_adr;
	logic                     visible;
	logic                     accept;
	logic                     last_pix;

	assign accept   = start && (state == sprite_pkg::IDLE); // Starts while busy are dropped.
	assign last_pix = (pix_cnt == PIX_BITS'(`SPRITE_PIX - 1));
	assign rom_word = rom_rsp.dat;
	assign busy     = (state != sprite_pkg::IDLE);

	sprite_addr i_sprite_addr (
		.x       (cmd_q.x),
		.y       (cmd_q.y),
		.pix     (pix_cnt),
		.fb_adr  (fb_adr),
		.visible (visible)
	);

	always_ff @(posedge clk) begin
		if (accept)
			cmd_q <= cmd;
		if (state == sprite_pkg::READ && rom_rsp.ack)
			word_q <= rom_word;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= sprite_pkg::IDLE;
			pix_cnt <= '0;
			done    <= 1'b0;
		end else begin
			state <= next_state;
			if (accept) begin
				pix_cnt <= '0;
				done    <= 1'b0;
			end else if (state == sprite_pkg::ADVANCE) begin
				if (last_pix)
					done <= 1'b1; // Same edge that takes the FSM back to IDLE.
				else
					pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			sprite_pkg::IDLE: begin
				if (start)
					next_state = sprite_pkg::READ;
			end
			sprite_pkg::READ: begin
				// Transparent or off-screen pixels skip the write cycle entirely.
				if (rom_rsp.ack)
					next_state = (visible && rom_word.opaque) ? sprite_pkg::WRITE
					                                          : sprite_pkg::ADVANCE;
			end
			sprite_pkg::WRITE: begin
				if (fb_rsp.ack)
					next_state = sprite_pkg::ADVANCE;
			end
			sprite_pkg::ADVANCE: begin
				next_state = last_pix ? sprite_pkg::IDLE : sprite_pkg::READ;
			end
			default: next_state = sprite_pkg::IDLE;
		endcase
	end

	// Requests are held for the whole state, so they drop in the cycle after ack.
	always_comb begin
		rom_req.cyc = (state == sprite_pkg::READ);
		rom_req.stb = (state == sprite_pkg::READ);
		rom_req.adr = {cmd_q.img, pix_cnt};
		fb_req.cyc  = (state == sprite_pkg::WRITE);
		fb_req.stb  = (state == sprite_pkg::WRITE);
		fb_req.we   = (state == sprite_pkg::WRITE);
		fb_req.adr  = fb_adr;
		fb_req.dat  = word_q.color;
	end

endmodule

//--- hw/draw_sprite/sprite_addr.sv
`include "sprite_cfg.svh"

module sprite_addr (
	input  logic [9:0]                     x,
	input  logic [8:0]                     y,
	input  logic [$clog2(`SPRITE_PIX)-1:0] pix,
	output logic [`FB_ADDR_BITS-1:0]       fb_adr,
	output logic                           visible
);

	localparam int DIM_BITS = $clog2(`SPRITE_DIM);

	logic [DIM_BITS-1:0] row;
	logic [DIM_BITS-1:0] col;
	logic [10:0]         scr_x; // One bit wider so the sum never wraps.
	logic [9:0]          scr_y;

	assign row = pix[2*DIM_BITS-1:DIM_BITS];
	assign col = pix[DIM_BITS-1:0];

	assign scr_x = {1'b0, x} + 11'(col);
	assign scr_y = {1'b0, y} + 10'(row);

	assign visible = (scr_x < 11'(`SCREEN_W)) && (scr_y < 10'(`SCREEN_H));

	// Row stride of 640 is 512 + 128. Only meaningful when visible is set.
	assign fb_adr = ({9'b0, scr_y} << 9) + ({9'b0, scr_y} << 7) + {8'b0, scr_x};

endmodule

//--- hw/frame_buffer.sv
`include "sprite_cfg.svh"

module frame_buffer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  wb_pkg::wb_wr_req_t       wb_req,
	output wb_pkg::wb_wr_rsp_t       wb_rsp,
	input  logic [`FB_ADDR_BITS-1:0] rd_addr,
	output sprite_pkg::color_t       rd_data
);

	sprite_pkg::color_t mem [0:`SCREEN_W*`SCREEN_H-1];
	logic               ack_q;
	logic               wr_hit;

	// Memory is written on the same edge that raises ack.
	assign wr_hit = wb_req.cyc && wb_req.stb && wb_req.we && !ack_q;

	always_ff @(posedge clk) begin
		if (wr_hit)
			mem[wb_req.adr] <= wb_req.dat;
		rd_data <= mem[rd_addr]; // Scan-out side.
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ack_q <= 1'b0;
		else
			ack_q <= wr_hit;
	end

	assign wb_rsp.ack = ack_q;

endmodule

//--- hw/sprite_engine.sv
`include "sprite_cfg.svh"

module sprite_engine (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      start,
	input  sprite_pkg::sprite_cmd_t   cmd,
	output logic                      done,
	output logic                      busy,
	input  logic                      ld_en,
	input  logic [`ROM_ADDR_BITS-1:0] ld_addr,
	input  logic [31:0]               ld_data,
	input  logic [`FB_ADDR_BITS-1:0]  rd_addr,
	output sprite_pkg::color_t        rd_data
);

	wb_pkg::wb_rd_req_t rom_req;
	wb_pkg::wb_rd_rsp_t rom_rsp;
	wb_pkg::wb_wr_req_t fb_req;
	wb_pkg::wb_wr_rsp_t fb_rsp;

	draw_sprite i_draw_sprite (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.cmd     (cmd),
		.done    (done),
		.busy    (busy),
		.rom_req (rom_req),
		.rom_rsp (rom_rsp),
		.fb_req  (fb_req),
		.fb_rsp  (fb_rsp)
	);

	sprite_store i_sprite_store (
		.clk     (clk),
		.rst_n   (rst_n),
		.ld_en   (ld_en),
		.ld_addr (ld_addr),
		.ld_data (ld_data),
		.wb_req  (rom_req),
		.wb_rsp  (rom_rsp)
	);

	frame_buffer i_frame_buffer (
		.clk     (clk),
		.rst_n   (rst_n),
		.wb_req  (fb_req),
		.wb_rsp  (fb_rsp),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

//--- hw/sprite_store.sv
`include "sprite_cfg.svh"

module sprite_store (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      ld_en,
	input  logic [`ROM_ADDR_BITS-1:0] ld_addr,
	input  sprite_pkg::sprite_word_t  ld_data,
	input  wb_pkg::wb_rd_req_t        wb_req,
	output wb_pkg::wb_rd_rsp_t        wb_rsp
);

	sprite_pkg::sprite_word_t mem [0:(1 << `ROM_ADDR_BITS)-1];
	sprite_pkg::sprite_word_t dat_q;
	logic                     ack_q;
	logic                     rd_hit;

	// No new access in the ack cycle, so ack stays a single pulse.
	assign rd_hit = wb_req.cyc && wb_req.stb && !ack_q;

	always_ff @(posedge clk) begin
		if (ld_en)
			mem[ld_addr] <= ld_data;
		if (rd_hit)
			dat_q <= mem[wb_req.adr];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ack_q <= 1'b0;
		else
			ack_q <= rd_hit;
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = dat_q;

endmodule

//--- sprite_engine.f
+incdir+common
common/sprite_pkg.sv
common/wb_pkg.sv
hw/draw_sprite/sprite_addr.sv
hw/draw_sprite/draw_sprite.sv
hw/sprite_store.sv
hw/frame_buffer.sv
hw/sprite_engine.sv
verification/sprite_engine_asserts.sv
verification/tb_sprite_engine.sv

//--- verification/sprite_engine_asserts.sv
`include "sprite_cfg.svh"

module sprite_engine_asserts (
	input logic                    clk,
	input logic                    rst_n,
	input sprite_pkg::draw_state_e state,
	input logic                    done,
	input logic                    busy,
	input wb_pkg::wb_rd_req_t      rom_req,
	input wb_pkg::wb_rd_rsp_t      rom_rsp,
	input wb_pkg::wb_wr_req_t      fb_req,
	input wb_pkg::wb_wr_rsp_t      fb_rsp
);

	int fail_cnt = 0; // Read by the testbench.

	a_rom_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		rom_req.stb |-> rom_req.cyc)
	else begin
		fail_cnt++;
		$error("Sprite store bus has stb without cyc.");
	end

	a_fb_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		fb_req.stb |-> fb_req.cyc)
	else begin
		fail_cnt++;
		$error("Frame buffer bus has stb without cyc.");
	end

	// A request may only end once the slave has acknowledged it.
	a_rom_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rom_req.stb && !rom_rsp.ack |=> rom_req.stb)
	else begin
		fail_cnt++;
		$error("Sprite store stb dropped before ack.");
	end

	a_fb_hold: assert property (@(posedge clk) disable iff (!rst_n)
		fb_req.stb && !fb_rsp.ack |=> fb_req.stb)
	else begin
		fail_cnt++;
		$error("Frame buffer stb dropped before ack.");
	end

	// Pixels below the last line must never reach the frame buffer bus.
	a_fb_on_screen: assert property (@(posedge clk) disable iff (!rst_n)
		fb_req.stb |-> fb_req.adr < `SCREEN_W * `SCREEN_H)
	else begin
		fail_cnt++;
		$error("Frame buffer write outside the screen.");
	end

	a_done_idle: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> !busy && state == sprite_pkg::IDLE)
	else begin
		fail_cnt++;
		$error("done is high while the engine is busy.");
	end

endmodule

bind draw_sprite sprite_engine_asserts i_asserts (
	.clk     (clk),
	.rst_n   (rst_n),
	.state   (state),
	.done    (done),
	.busy    (busy),
	.rom_req (rom_req),
	.rom_rsp (rom_rsp),
	.fb_req  (fb_req),
	.fb_rsp  (fb_rsp)
);

//--- verification/tb_sprite_engine.sv
`include "sprite_cfg.svh"

module tb_sprite_engine;

	localparam int TIMEOUT = 1000;

	logic                      clk;
	logic                      rst_n;
	logic                      start;
	sprite_pkg::sprite_cmd_t   cmd;
	logic                      done;
	logic                      busy;
	logic                      ld_en;
	logic [`ROM_ADDR_BITS-1:0] ld_addr;
	logic [31:0]               ld_data;
	logic [`FB_ADDR_BITS-1:0]  rd_addr;
	sprite_pkg::color_t        rd_data;

	integer                   seed;
	sprite_pkg::sprite_word_t model_rom [0:(1 << `ROM_ADDR_BITS)-1];
	sprite_pkg::color_t       model_fb [int]; // Only addresses the model has written.

	sprite_engine i_dut (.*);

	always #5 clk = ~clk;

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_color(input string name, input sprite_pkg::color_t exp,
			input sprite_pkg::color_t act);
		if (act !== exp)
			stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h",
				$time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_on_error($sformatf("** Error at %0t: %s expected %b, got %b",
				$time, name, exp, act));
	endtask

	task automatic check_word(input string name, input sprite_pkg::sprite_word_t exp,
			input sprite_pkg::sprite_word_t act);
		if (act !== exp)
			stop_on_error($sformatf("** Error at %0t: %s expected %h, got %h",
				$time, name, exp, act));
	endtask

	// Mode 0 is opaque black, 1 is opaque random colour, 2 has random opaque flags.
	task automatic load_sprite(input int img, input int mode);
		sprite_pkg::sprite_word_t  w;
		logic [`ROM_ADDR_BITS-1:0] a;
		for (int p = 0; p < `SPRITE_PIX; p++) begin
			w = $random(seed);
			if (mode == 0)
				w.color = '0;
			if (mode != 2)
				w.opaque = 1'b1;
			a = {img[`IMG_BITS-1:0], p[5:0]};
			model_rom[a] = w;
			@(posedge clk);
			#1;
			ld_en   = 1'b1;
			ld_addr = a;
			ld_data = w;
		end
		@(posedge clk);
		#1;
		ld_en = 1'b0;
		for (int p = 0; p < `SPRITE_PIX; p++) begin
			a = {img[`IMG_BITS-1:0], p[5:0]};
			check_word($sformatf("sprite_store.mem[%0d]", a), model_rom[a],
				i_dut.i_sprite_store.mem[a]);
		end
	endtask

	function automatic void model_draw(input sprite_pkg::sprite_cmd_t c);
		sprite_pkg::sprite_word_t w;
		int                       sx;
		int                       sy;
		for (int p = 0; p < `SPRITE_PIX; p++) begin
			w  = model_rom[{c.img, p[5:0]}];
			sx = c.x + p % `SPRITE_DIM;
			sy = c.y + p / `SPRITE_DIM;
			if (w.opaque && sx < `SCREEN_W && sy < `SCREEN_H)
				model_fb[sy * `SCREEN_W + sx] = w.color;
		end
	endfunction

	// With restart set a second command is offered while the first one runs.
	task automatic run_draw(input int x, input int y, input int img, input bit restart);
		sprite_pkg::sprite_cmd_t c;
		int                      n;
		c = '{x: x[9:0], y: y[8:0], img: img[`IMG_BITS-1:0]};
		@(posedge clk);
		#1;
		start = 1'b1;
		cmd   = c;
		@(posedge clk);
		#1;
		start = 1'b0;
		@(negedge clk);
		check_flag("busy", 1'b1, busy);
		check_flag("done", 1'b0, done);
		if (restart) begin
			@(posedge clk);
			#1;
			start = 1'b1;
			cmd   = '{x: c.x, y: c.y, img: c.img + 1'b1};
			@(posedge clk);
			#1;
			start = 1'b0;
		end
		for (n = 0; !done; n++) begin
			if (n == TIMEOUT)
				stop_on_error("Timeout: done did not rise after an accepted start.");
			check_flag("busy", 1'b1, busy);
			@(negedge clk);
		end
		check_flag("busy", 1'b0, busy); // Falls in the cycle where done rises.
		model_draw(c);
		if (restart) begin
			repeat (20) begin
				@(negedge clk);
				check_flag("done", 1'b1, done);
				check_flag("busy", 1'b0, busy);
			end
		end
	endtask

	task automatic check_region(input int x0, input int y0, input int w, input int h);
		int a;
		for (int y = y0; y < y0 + h; y++) begin
			for (int x = x0; x < x0 + w; x++) begin
				a = y * `SCREEN_W + x;
				if (model_fb.exists(a)) begin
					@(posedge clk);
					#1;
					rd_addr = a[`FB_ADDR_BITS-1:0];
					@(posedge clk);
					@(negedge clk);
					check_color($sformatf("rd_data[%0d]", a), model_fb[a], rd_data);
				end
			end
		end
	endtask

	always @(negedge clk) begin
		if (i_dut.i_draw_sprite.i_asserts.fail_cnt != 0)
			stop_on_error("A bus or status assertion failed.");
	end

	initial begin
		int rx;
		int ry;
		int ri;
		seed    = 32'h8bef_adf0;
		clk     = 1'b0;
		rst_n   = 1'b0;
		start   = 1'b0;
		cmd     = '0;
		ld_en   = 1'b0;
		ld_addr = '0;
		ld_data = '0;
		rd_addr = '0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_flag("done", 1'b0, done);
		check_flag("busy", 1'b0, busy);
		load_sprite(0, 0);
		load_sprite(1, 1);
		for (int i = 2; i < 8; i++)
			load_sprite(i, 2);
		run_draw(100, 50, 1, 1'b0); // Opaque, well inside the screen.
		check_region(100, 50, 8, 8);
		run_draw(100, 50, 2, 1'b0); // Holes keep the colours below.
		check_region(100, 50, 8, 8);
		run_draw(632, 472, 0, 1'b0);
		run_draw(0, 472, 0, 1'b0); // Where clipped pixels would wrap to.
		run_draw(636, 476, 1, 1'b0);
		check_region(632, 472, 8, 8);
		check_region(0, 472, 8, 8);
		run_draw(300, 200, 0, 1'b0);
		run_draw(300, 200, 1, 1'b1);
		check_region(300, 200, 8, 8);
		for (int y = 100; y < 140; y += 8) begin
			for (int x = 200; x < 240; x += 8)
				run_draw(x, y, 0, 1'b0);
		end
		for (int i = 0; i < 12; i++) begin
			rx = $unsigned($random(seed)) % 32;
			ry = $unsigned($random(seed)) % 32;
			ri = 1 + $unsigned($random(seed)) % 7;
			run_draw(200 + rx, 100 + ry, ri, 1'b0);
		end
		check_region(200, 100, 40, 40);
		if (i_dut.i_draw_sprite.i_asserts.fail_cnt == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
